// ==== mycpu_defs.svh ====
`ifndef MYCPU_DEFS_SVH
`define MYCPU_DEFS_SVH

// first fetch address after reset
`define MYCPU_RESET_PC 32'h1c00_0000

// data and address width
`define MYCPU_XLEN 32

// register index width
`define MYCPU_RIDX 5

`endif

// ==== source/cpu_pkg.sv ====
`default_nettype none

`include "mycpu_defs.svh"

package cpu_pkg;

    typedef enum logic [2:0] {
        S_IF,
        S_ID,
        S_EXE,
        S_MEM,
        S_WB
    } cpu_state_t;

    typedef enum logic [3:0] {
        ADD,
        SUB,
        SLT,
        SLTU,
        AND,
        NOR,
        OR,
        XOR,
        SLL,
        SRL,
        SRA,
        LUI                                     // src2 passthrough
    } alu_op_t;

    typedef struct packed {
        alu_op_t                alu_op;
        logic [`MYCPU_RIDX-1:0] rj;
        logic [`MYCPU_RIDX-1:0] rk_or_rd;       // rd for beq/bne/st.w
        logic [`MYCPU_RIDX-1:0] dest;           // r1 for bl
        logic [`MYCPU_XLEN-1:0] imm;            // 4 for jirl/bl
        logic [`MYCPU_XLEN-1:0] br_offs;        // already << 2
        logic                   src1_is_pc;
        logic                   src2_is_imm;
        logic                   gr_we;
        logic                   mem_we;
        logic                   res_from_mem;
        logic                   is_jirl;
        logic                   is_b_uncond;    // b and bl
        logic                   is_beq;
        logic                   is_bne;
    } decoded_t;

    typedef struct packed {
        logic [`MYCPU_XLEN-1:0] pc;
        logic [3:0]             we;
        logic [`MYCPU_RIDX-1:0] wnum;
        logic [`MYCPU_XLEN-1:0] wdata;
    } wb_trace_t;

endpackage

`default_nettype wire

// ==== source/inst_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mycpu_defs.svh"

module inst_decode (
    input  wire [`MYCPU_XLEN-1:0] inst,
    output cpu_pkg::decoded_t     dec
);
    import cpu_pkg::*;

    logic [5:0]  op_31_26;
    logic [3:0]  op_25_22;
    logic [1:0]  op_21_20;
    logic [4:0]  op_19_15;
    logic [4:0]  rd;
    logic [4:0]  rj;
    logic [4:0]  rk;
    logic [11:0] i12;
    logic [19:0] i20;
    logic [15:0] i16;
    logic [25:0] i26;
    logic        rr_grp;
    logic        sh_grp;

    logic inst_add_w, inst_sub_w, inst_slt, inst_sltu;
    logic inst_nor, inst_and, inst_or, inst_xor;
    logic inst_slli_w, inst_srli_w, inst_srai_w;
    logic inst_addi_w, inst_lu12i_w, inst_ld_w, inst_st_w;
    logic inst_jirl, inst_b, inst_bl, inst_beq, inst_bne;
    logic need_ui5, need_si12, need_si20, need_si26;
    logic src2_is_4, src_reg_is_rd;

    assign op_31_26 = inst[31:26];
    assign op_25_22 = inst[25:22];
    assign op_21_20 = inst[21:20];
    assign op_19_15 = inst[19:15];
    assign rd       = inst[4:0];
    assign rj       = inst[9:5];
    assign rk       = inst[14:10];
    assign i12      = inst[21:10];
    assign i20      = inst[24:5];
    assign i16      = inst[25:10];
    assign i26      = {inst[9:0], inst[25:10]};   // offs[25:16] sits low

    assign rr_grp = (op_31_26 == 6'h00) && (op_25_22 == 4'h0) && (op_21_20 == 2'h1);
    assign sh_grp = (op_31_26 == 6'h00) && (op_25_22 == 4'h1) && (op_21_20 == 2'h0);

    assign inst_add_w   = rr_grp && (op_19_15 == 5'h00);
    assign inst_sub_w   = rr_grp && (op_19_15 == 5'h02);
    assign inst_slt     = rr_grp && (op_19_15 == 5'h04);
    assign inst_sltu    = rr_grp && (op_19_15 == 5'h05);
    assign inst_nor     = rr_grp && (op_19_15 == 5'h08);
    assign inst_and     = rr_grp && (op_19_15 == 5'h09);
    assign inst_or      = rr_grp && (op_19_15 == 5'h0a);
    assign inst_xor     = rr_grp && (op_19_15 == 5'h0b);
    assign inst_slli_w  = sh_grp && (op_19_15 == 5'h01);
    assign inst_srli_w  = sh_grp && (op_19_15 == 5'h09);
    assign inst_srai_w  = sh_grp && (op_19_15 == 5'h11);
    assign inst_addi_w  = (op_31_26 == 6'h00) && (op_25_22 == 4'ha);
    assign inst_ld_w    = (op_31_26 == 6'h0a) && (op_25_22 == 4'h2);
    assign inst_st_w    = (op_31_26 == 6'h0a) && (op_25_22 == 4'h6);
    assign inst_jirl    = (op_31_26 == 6'h13);
    assign inst_b       = (op_31_26 == 6'h14);
    assign inst_bl      = (op_31_26 == 6'h15);
    assign inst_beq     = (op_31_26 == 6'h16);
    assign inst_bne     = (op_31_26 == 6'h17);
    assign inst_lu12i_w = (op_31_26 == 6'h05) && !inst[25];

    assign need_ui5      = inst_slli_w | inst_srli_w | inst_srai_w;
    assign need_si12     = inst_addi_w | inst_ld_w | inst_st_w;
    assign need_si20     = inst_lu12i_w;
    assign need_si26     = inst_b | inst_bl;
    assign src2_is_4     = inst_jirl | inst_bl;     // link value pc + 4
    assign src_reg_is_rd = inst_beq | inst_bne | inst_st_w;

    always_comb begin
        dec          = '0;
        dec.rj       = rj;
        dec.rk_or_rd = src_reg_is_rd ? rd : rk;
        dec.dest     = inst_bl ? 5'd1 : rd;

        case (1'b1)
            inst_sub_w:   dec.alu_op = SUB;
            inst_slt:     dec.alu_op = SLT;
            inst_sltu:    dec.alu_op = SLTU;
            inst_and:     dec.alu_op = AND;
            inst_nor:     dec.alu_op = NOR;
            inst_or:      dec.alu_op = OR;
            inst_xor:     dec.alu_op = XOR;
            inst_slli_w:  dec.alu_op = SLL;
            inst_srli_w:  dec.alu_op = SRL;
            inst_srai_w:  dec.alu_op = SRA;
            inst_lu12i_w: dec.alu_op = LUI;
            default:      dec.alu_op = ADD;         // add, addi, ld/st, links
        endcase

        if (src2_is_4)
            dec.imm = 32'd4;
        else if (need_si20)
            dec.imm = {i20, 12'b0};
        else if (need_ui5)
            dec.imm = {27'b0, rk};
        else if (need_si12)
            dec.imm = {{20{i12[11]}}, i12};

        dec.br_offs = need_si26 ? {{4{i26[25]}}, i26, 2'b0}
                                : {{14{i16[15]}}, i16, 2'b0};

        dec.src1_is_pc   = inst_jirl | inst_bl;
        dec.src2_is_imm  = need_ui5 | need_si12 | need_si20 | src2_is_4;
        dec.gr_we        = inst_add_w | inst_sub_w | inst_slt | inst_sltu
                         | inst_nor | inst_and | inst_or | inst_xor
                         | need_ui5 | inst_addi_w | inst_lu12i_w
                         | inst_ld_w | inst_jirl | inst_bl;
        dec.mem_we       = inst_st_w;
        dec.res_from_mem = inst_ld_w;
        dec.is_jirl      = inst_jirl;
        dec.is_b_uncond  = inst_b | inst_bl;
        dec.is_beq       = inst_beq;
        dec.is_bne       = inst_bne;

        assert ($onehot0({dec.is_jirl, dec.is_b_uncond, dec.is_beq, dec.is_bne}));
    end

endmodule

`default_nettype wire

// ==== source/alu.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mycpu_defs.svh"

module alu (
    input  var cpu_pkg::alu_op_t       op,
    input  wire [`MYCPU_XLEN-1:0]     src1,
    input  wire [`MYCPU_XLEN-1:0]     src2,
    output logic [`MYCPU_XLEN-1:0]    result
);
    import cpu_pkg::*;

    logic [4:0] shamt;

    assign shamt = src2[4:0];

    always_comb begin
        case (op)
            ADD:     result = src1 + src2;
            SUB:     result = src1 - src2;
            SLT:     result = {31'b0, $signed(src1) < $signed(src2)};
            SLTU:    result = {31'b0, src1 < src2};
            AND:     result = src1 & src2;
            NOR:     result = ~(src1 | src2);
            OR:      result = src1 | src2;
            XOR:     result = src1 ^ src2;
            SLL:     result = src1 << shamt;
            SRL:     result = src1 >> shamt;
            SRA:     result = $unsigned($signed(src1) >>> shamt);
            LUI:     result = src2;                 // imm already << 12
            default: result = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== source/regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mycpu_defs.svh"

module regfile (
    input  wire                     clk,
    input  wire [`MYCPU_RIDX-1:0]   raddr1,
    input  wire [`MYCPU_RIDX-1:0]   raddr2,
    output logic [`MYCPU_XLEN-1:0]  rdata1,
    output logic [`MYCPU_XLEN-1:0]  rdata2,
    input  wire                     we,
    input  wire [`MYCPU_RIDX-1:0]   waddr,
    input  wire [`MYCPU_XLEN-1:0]   wdata
);

    logic [`MYCPU_XLEN-1:0] rf [31:1];              // no storage for r0

    always_ff @(posedge clk) begin
        if (we && (waddr != '0))
            rf[waddr] <= wdata;
    end

    assign rdata1 = (raddr1 == '0) ? '0 : rf[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : rf[raddr2];

    // r0 stays zero even right after a write aimed at it
    a_r0_zero: assert property (@(posedge clk)
        (we && (waddr == '0)) |=> ((raddr1 != '0) || (rdata1 == '0))
                                && ((raddr2 != '0) || (rdata2 == '0)));

endmodule

`default_nettype wire

// ==== source/mycpu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mycpu_defs.svh"

module mycpu_top (
    input  wire                     clk,
    input  wire                     reset,
    output logic                    inst_sram_we,
    output logic [`MYCPU_XLEN-1:0]  inst_sram_addr,
    output logic [`MYCPU_XLEN-1:0]  inst_sram_wdata,
    input  wire [`MYCPU_XLEN-1:0]   inst_sram_rdata,
    output logic                    data_sram_we,
    output logic [`MYCPU_XLEN-1:0]  data_sram_addr,
    output logic [`MYCPU_XLEN-1:0]  data_sram_wdata,
    input  wire [`MYCPU_XLEN-1:0]   data_sram_rdata,
    output logic [`MYCPU_XLEN-1:0]  debug_wb_pc,
    output logic [3:0]              debug_wb_rf_we,
    output logic [`MYCPU_RIDX-1:0]  debug_wb_rf_wnum,
    output logic [`MYCPU_XLEN-1:0]  debug_wb_rf_wdata
);
    import cpu_pkg::*;

    cpu_state_t             state;
    cpu_state_t             state_next;
    decoded_t               dec;
    wb_trace_t              trace;

    logic [`MYCPU_XLEN-1:0] pc;
    logic [`MYCPU_XLEN-1:0] ir;
    logic [`MYCPU_XLEN-1:0] inst_word;
    logic [`MYCPU_XLEN-1:0] rj_q;
    logic [`MYCPU_XLEN-1:0] rkd_q;
    logic [`MYCPU_XLEN-1:0] load_q;
    logic [`MYCPU_XLEN-1:0] rf_rdata1;
    logic [`MYCPU_XLEN-1:0] rf_rdata2;
    logic [`MYCPU_XLEN-1:0] alu_src1;
    logic [`MYCPU_XLEN-1:0] alu_src2;
    logic [`MYCPU_XLEN-1:0] alu_result;
    logic [`MYCPU_XLEN-1:0] seq_pc;
    logic [`MYCPU_XLEN-1:0] br_target;
    logic [`MYCPU_XLEN-1:0] wb_data;
    logic                   br_only;
    logic                   br_taken;
    logic                   jump_link;
    logic                   redirect;
    logic                   rf_we;

    // the fetched word only arrives in ID, the IR holds it afterwards
    assign inst_word = (state == S_ID) ? inst_sram_rdata : ir;

    inst_decode u_decode (
        .inst (inst_word),
        .dec  (dec)
    );

    regfile u_regfile (
        .clk    (clk),
        .raddr1 (dec.rj),
        .raddr2 (dec.rk_or_rd),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2),
        .we     (rf_we),
        .waddr  (dec.dest),
        .wdata  (wb_data)
    );

    assign alu_src1 = dec.src1_is_pc ? pc : rj_q;
    assign alu_src2 = dec.src2_is_imm ? dec.imm : rkd_q;

    alu u_alu (
        .op     (dec.alu_op),
        .src1   (alu_src1),
        .src2   (alu_src2),
        .result (alu_result)
    );

    assign br_only   = dec.is_beq | dec.is_bne | (dec.is_b_uncond & ~dec.gr_we);
    assign br_taken  = dec.is_b_uncond
                     | (dec.is_beq && (rf_rdata1 == rf_rdata2))
                     | (dec.is_bne && (rf_rdata1 != rf_rdata2));
    assign jump_link = dec.is_jirl | (dec.is_b_uncond & dec.gr_we);   // jirl, bl
    assign redirect  = (state == S_ID) ? br_taken : jump_link;
    assign seq_pc    = pc + 32'd4;
    assign br_target = (dec.is_jirl ? rj_q : pc) + dec.br_offs;

    always_comb begin
        case (state)
            S_IF:    state_next = S_ID;
            S_ID:    state_next = br_only ? S_IF : S_EXE;
            S_EXE:   state_next = (dec.mem_we | dec.res_from_mem) ? S_MEM : S_WB;
            S_MEM:   state_next = dec.res_from_mem ? S_WB : S_IF;
            S_WB:    state_next = S_IF;
            default: state_next = S_IF;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= S_IF;
            pc    <= `MYCPU_RESET_PC;
        end else begin
            state <= state_next;
            if (state_next == S_IF)                 // last cycle of this inst
                pc <= redirect ? br_target : seq_pc;
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_ID) begin
            ir    <= inst_sram_rdata;
            rj_q  <= rf_rdata1;
            rkd_q <= rf_rdata2;
        end
        if (state == S_MEM)
            load_q <= data_sram_rdata;
    end

    assign inst_sram_we    = 1'b0;
    assign inst_sram_addr  = pc;
    assign inst_sram_wdata = '0;

    assign data_sram_we    = (state == S_EXE) && dec.mem_we;
    assign data_sram_addr  = alu_result;
    assign data_sram_wdata = rkd_q;

    assign wb_data = dec.res_from_mem ? load_q : alu_result;
    assign rf_we   = (state == S_WB) && dec.gr_we && (dec.dest != '0);

    assign trace.pc    = pc;
    assign trace.we    = {4{rf_we}};
    assign trace.wnum  = dec.dest;
    assign trace.wdata = wb_data;

    assign debug_wb_pc       = trace.pc;
    assign debug_wb_rf_we    = trace.we;
    assign debug_wb_rf_wnum  = trace.wnum;
    assign debug_wb_rf_wdata = trace.wdata;

    a_store_in_exe: assert property (@(posedge clk) disable iff (reset)
        data_sram_we |-> (state == S_EXE) && $past(state == S_ID));

    a_trace_in_wb: assert property (@(posedge clk) disable iff (reset)
        (debug_wb_rf_we != '0) |-> (state == S_WB));

    // every state lasts one cycle
    a_state_moves: assert property (@(posedge clk) disable iff (reset)
        !$past(reset) |-> (state != $past(state)));

endmodule

`default_nettype wire

// ==== verif/trace_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mycpu_defs.svh"

module trace_checker #(
    parameter int MAXEV = 36
) (
    input  wire                     clk,
    input  wire                     reset,
    input  wire [`MYCPU_XLEN-1:0]   fetch_addr,
    input  wire                     inst_we,
    input  wire [`MYCPU_XLEN-1:0]   inst_wdata,
    input  var cpu_pkg::wb_trace_t  trace,
    input  wire                     store_we,
    input  wire [`MYCPU_XLEN-1:0]   store_addr,
    input  wire [`MYCPU_XLEN-1:0]   store_data,
    input  var cpu_pkg::wb_trace_t  exp_ev [MAXEV],
    input  var logic [1:0]          exp_kind [MAXEV],
    input  var int                  exp_gap [MAXEV],
    input  var int                  n_ev,
    output int                      errors,
    output int                      seen
);
    import cpu_pkg::*;

    localparam logic [1:0] EV_TRACE = 2'd1;
    localparam logic [1:0] EV_STORE = 2'd2;

    int cyc;                                        // 0 is the first fetch cycle
    int last_cyc;

    function automatic int report_diff(string name, logic [31:0] got, logic [31:0] exp);
        if (got !== exp) begin
            $display("MISMATCH %s got %h expected %h", name, got, exp);
            return 1;
        end
        return 0;
    endfunction

    always @(posedge clk) begin
        int bad;
        bad = 0;
        if (reset) begin
            cyc      <= 0;
            last_cyc <= 0;
            errors   <= 0;
            seen     <= 0;
        end else begin
            if (cyc == 0)
                bad += report_diff("inst_sram_addr", fetch_addr, `MYCPU_RESET_PC);
            // instruction port is read only
            bad += report_diff("inst_sram_we", {31'b0, inst_we}, 32'h0);
            bad += report_diff("inst_sram_wdata", inst_wdata, 32'h0);
            if ((trace.we != '0) || store_we) begin
                if (seen >= n_ev) begin
                    $display("unexpected write at cycle %0d after the last expected event", cyc);
                    bad++;
                end else if ((trace.we != '0) && (exp_kind[seen] != EV_TRACE)) begin
                    $display("register write at cycle %0d where a store was expected", cyc);
                    bad++;
                end else if (store_we && (exp_kind[seen] != EV_STORE)) begin
                    $display("store at cycle %0d where a register write was expected", cyc);
                    bad++;
                end else if (store_we) begin
                    bad += report_diff("data_sram_addr", store_addr, exp_ev[seen].pc);
                    bad += report_diff("data_sram_wdata", store_data, exp_ev[seen].wdata);
                end else begin
                    bad += report_diff("debug_wb_pc", trace.pc, exp_ev[seen].pc);
                    bad += report_diff("debug_wb_rf_we", {28'b0, trace.we},
                                       {28'b0, exp_ev[seen].we});
                    bad += report_diff("debug_wb_rf_wnum", {27'b0, trace.wnum},
                                       {27'b0, exp_ev[seen].wnum});
                    bad += report_diff("debug_wb_rf_wdata", trace.wdata, exp_ev[seen].wdata);
                end
                if (seen < n_ev)
                    bad += report_diff("event_gap", cyc - last_cyc, exp_gap[seen]);
                last_cyc <= cyc;
                seen     <= seen + 1;
            end
            cyc    <= cyc + 1;
            errors <= errors + bad;
        end
    end

endmodule

`default_nettype wire

// ==== verif/tb_mycpu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mycpu_defs.svh"

module tb_mycpu_top;
    import cpu_pkg::*;

    localparam int N     = 36;
    localparam int LIMIT = 8 + 5 * N + 20;
    localparam logic [1:0] NONE  = 2'd0;
    localparam logic [1:0] TRACE = 2'd1;
    localparam logic [1:0] STORE = 2'd2;
    localparam logic [1:0] SKIP  = 2'd3;            // jumped over, never runs

    typedef struct packed {
        logic [31:0] word;
        logic [1:0]  kind;
        logic [2:0]  cyc;                           // class cycle count
        logic [4:0]  wnum;
        logic [31:0] addr;
        logic [31:0] val;
    } prog_entry_t;

    logic        clk;
    logic        reset;
    logic [31:0] inst_sram_rdata;
    logic [31:0] data_sram_rdata;
    logic        inst_sram_we;
    logic [31:0] inst_sram_addr;
    logic [31:0] inst_sram_wdata;
    logic        data_sram_we;
    logic [31:0] data_sram_addr;
    logic [31:0] data_sram_wdata;
    wb_trace_t   trace;

    prog_entry_t prog [N];
    logic [31:0] rom [64];
    logic [31:0] dram [64];
    logic [31:0] dram_init [64];
    wb_trace_t   exp_ev [N];
    logic [1:0]  exp_kind [N];
    int          exp_gap [N];
    int          n_ev;
    int          errors;
    int          seen;
    int          cycles;
    logic        timed_out;

    mycpu_top UUT (
        .clk               (clk),
        .reset             (reset),
        .inst_sram_we      (inst_sram_we),
        .inst_sram_addr    (inst_sram_addr),
        .inst_sram_wdata   (inst_sram_wdata),
        .inst_sram_rdata   (inst_sram_rdata),
        .data_sram_we      (data_sram_we),
        .data_sram_addr    (data_sram_addr),
        .data_sram_wdata   (data_sram_wdata),
        .data_sram_rdata   (data_sram_rdata),
        .debug_wb_pc       (trace.pc),
        .debug_wb_rf_we    (trace.we),
        .debug_wb_rf_wnum  (trace.wnum),
        .debug_wb_rf_wdata (trace.wdata)
    );

    trace_checker #(.MAXEV(N)) u_checker (
        .clk        (clk),
        .reset      (reset),
        .fetch_addr (inst_sram_addr),
        .inst_we    (inst_sram_we),
        .inst_wdata (inst_sram_wdata),
        .trace      (trace),
        .store_we   (data_sram_we),
        .store_addr (data_sram_addr),
        .store_data (data_sram_wdata),
        .exp_ev     (exp_ev),
        .exp_kind   (exp_kind),
        .exp_gap    (exp_gap),
        .n_ev       (n_ev),
        .errors     (errors),
        .seen       (seen)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin                     // both memories answer next cycle
        cycles          <= cycles + 1;
        inst_sram_rdata <= rom[inst_sram_addr[7:2]];
        data_sram_rdata <= dram[data_sram_addr[7:2]];
        if (data_sram_we)
            dram[data_sram_addr[7:2]] <= data_sram_wdata;
    end

    function automatic logic [31:0] rr_word(logic [4:0] code, logic [4:0] rd,
                                            logic [4:0] rj, logic [4:0] rk);
        return {6'h00, 4'h0, 2'h1, code, rk, rj, rd};
    endfunction

    function automatic logic [31:0] shift_word(logic [4:0] code, logic [4:0] rd,
                                               logic [4:0] rj, logic [4:0] ui5);
        return {6'h00, 4'h1, 2'h0, code, ui5, rj, rd};
    endfunction

    function automatic logic [31:0] imm12_word(logic [3:0] op, logic [4:0] rd,
                                               logic [4:0] rj, logic [11:0] si12);
        return {(op == 4'ha) ? 6'h00 : 6'h0a, op, si12, rj, rd};
    endfunction

    function automatic logic [31:0] off16_word(logic [5:0] op, logic [4:0] rd,
                                               logic [4:0] rj, logic [15:0] offs);
        return {op, offs, rj, rd};
    endfunction

    function automatic logic [31:0] off26_word(logic [5:0] op, logic [25:0] offs);
        return {op, offs[15:0], offs[25:16]};
    endfunction

    task automatic put(int i, logic [31:0] word, logic [1:0] kind, logic [2:0] cyc,
                       logic [4:0] wnum, logic [31:0] addr, logic [31:0] val);
        prog[i] = '{word, kind, cyc, wnum, addr, val};
    endtask

    task automatic load_program();
        put(0,  {6'h05, 1'b0, 20'h80001, 5'd2}, TRACE, 4, 2, 0, 32'h8000_1000);
        put(1,  imm12_word(4'ha, 3, 0, 12'hffb), TRACE, 4, 3, 0, 32'hffff_fffb);
        put(2,  imm12_word(4'ha, 4, 0, 12'h123), TRACE, 4, 4, 0, 32'h0000_0123);
        put(3,  rr_word(5'h00, 5, 2, 3), TRACE, 4, 5, 0, 32'h8000_0ffb);
        put(4,  rr_word(5'h02, 6, 4, 3), TRACE, 4, 6, 0, 32'h0000_0128);
        put(5,  rr_word(5'h04, 7, 3, 4), TRACE, 4, 7, 0, 32'h1);   // signed -5 < 0x123
        put(6,  rr_word(5'h05, 8, 3, 4), TRACE, 4, 8, 0, 32'h0);
        put(7,  rr_word(5'h08, 9, 4, 3), TRACE, 4, 9, 0, 32'h0000_0004);
        put(8,  rr_word(5'h09, 10, 2, 5), TRACE, 4, 10, 0, 32'h8000_0000);
        put(9,  rr_word(5'h0a, 11, 4, 2), TRACE, 4, 11, 0, 32'h8000_1123);
        put(10, rr_word(5'h0b, 12, 5, 2), TRACE, 4, 12, 0, 32'h0000_1ffb);
        put(11, shift_word(5'h01, 13, 4, 4), TRACE, 4, 13, 0, 32'h0000_1230);
        put(12, shift_word(5'h09, 14, 2, 4), TRACE, 4, 14, 0, 32'h0800_0100);
        put(13, shift_word(5'h11, 15, 2, 4), TRACE, 4, 15, 0, 32'hf800_0100);
        put(14, imm12_word(4'ha, 16, 0, 12'h040), TRACE, 4, 16, 0, 32'h0000_0040);
        put(15, imm12_word(4'h6, 5, 16, 12'h008), STORE, 4, 0, 32'h48, 32'h8000_0ffb);
        put(16, imm12_word(4'h2, 17, 16, 12'h008), TRACE, 5, 17, 0, 32'h8000_0ffb);
        put(17, imm12_word(4'h2, 18, 16, 12'h020), TRACE, 5, 18, 0, dram_init[24]);
        put(18, rr_word(5'h00, 0, 4, 4), NONE, 4, 0, 0, 0);        // write to r0 dropped
        put(19, rr_word(5'h00, 19, 0, 4), TRACE, 4, 19, 0, 32'h0000_0123);
        put(20, off16_word(6'h16, 6, 4, 16'd2), NONE, 2, 0, 0, 0);  // beq not taken
        put(21, off16_word(6'h17, 6, 4, 16'd2), NONE, 2, 0, 0, 0);  // bne taken
        put(22, imm12_word(4'ha, 20, 0, 12'h001), SKIP, 0, 0, 0, 0);
        put(23, off16_word(6'h16, 3, 3, 16'd2), NONE, 2, 0, 0, 0);  // beq taken
        put(24, imm12_word(4'ha, 20, 0, 12'h002), SKIP, 0, 0, 0, 0);
        put(25, off26_word(6'h15, 26'd2), TRACE, 4, 1, 0, 32'h1c00_0068);
        put(26, imm12_word(4'ha, 20, 0, 12'h003), SKIP, 0, 0, 0, 0);
        put(27, off26_word(6'h14, 26'd2), NONE, 2, 0, 0, 0);
        put(28, imm12_word(4'ha, 20, 0, 12'h004), SKIP, 0, 0, 0, 0);
        put(29, off16_word(6'h17, 3, 3, 16'd2), NONE, 2, 0, 0, 0);  // bne not taken
        put(30, {6'h05, 1'b0, 20'h1c000, 5'd21}, TRACE, 4, 21, 0, 32'h1c00_0000);
        put(31, off16_word(6'h13, 22, 21, 16'd34), TRACE, 4, 22, 0, 32'h1c00_0080);
        put(32, imm12_word(4'ha, 20, 0, 12'h006), SKIP, 0, 0, 0, 0);
        put(33, imm12_word(4'ha, 20, 0, 12'h007), SKIP, 0, 0, 0, 0);
        put(34, imm12_word(4'h2, 23, 16, 12'h03c), TRACE, 5, 23, 0, dram_init[31]);
        put(35, off26_word(6'h14, 26'd0), NONE, 2, 0, 0, 0);        // park here
    endtask

    initial begin
        int start;
        int prev;
        int e;
        reset           = 1'b1;
        inst_sram_rdata = '0;
        data_sram_rdata = '0;
        cycles          = 0;
        timed_out       = 1'b0;
        void'($urandom(32'h77f3));
        for (int k = 0; k < 64; k++) begin
            dram_init[k] = $urandom();
            dram[k]      = dram_init[k];
            rom[k]       = {26'b0, k[5:0]};
        end
        load_program();
        n_ev  = 0;
        start = 0;
        prev  = 0;
        for (int i = 0; i < N; i++) begin
            rom[i] = prog[i].word;
            if (prog[i].kind == TRACE || prog[i].kind == STORE) begin
                e = (prog[i].kind == STORE) ? start + 2 : start + int'(prog[i].cyc) - 1;
                exp_ev[n_ev]   = '{`MYCPU_RESET_PC + 4 * i, 4'hf, prog[i].wnum, prog[i].val};
                if (prog[i].kind == STORE)
                    exp_ev[n_ev] = '{prog[i].addr, 4'h0, 5'd0, prog[i].val};
                exp_kind[n_ev] = prog[i].kind;
                exp_gap[n_ev]  = e - prev;
                prev = e;
                n_ev++;
            end
            start += int'(prog[i].cyc);
        end
        for (int i = n_ev; i < N; i++) begin
            exp_ev[i]   = '0;
            exp_kind[i] = NONE;
            exp_gap[i]  = 0;
        end

        repeat (8) @(posedge clk);
        reset <= 1'b0;
        while (seen < n_ev && cycles < LIMIT)
            @(posedge clk);
        if (seen < n_ev)
            timed_out = 1'b1;
        else
            repeat (10) @(posedge clk);             // catch stray writes
        if (timed_out)
            $display("timeout after %0d cycles, only %0d of %0d events seen",
                     LIMIT, seen, n_ev);
        $display("errors: %0d, events seen: %0d of %0d", errors, seen, n_ev);
        if (!timed_out && errors == 0 && seen == n_ev) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== mycpu_top.f ====
+incdir+.
source/cpu_pkg.sv
source/inst_decode.sv
source/alu.sv
source/regfile.sv
source/mycpu_top.sv
verif/trace_checker.sv
verif/tb_mycpu_top.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_mycpu_top
FLIST     ?= mycpu_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FLIST BUILD_DIR LOG VFLAGS"

$(SIM_BIN): $(FLIST) mycpu_defs.svh source/*.sv verif/*.sv
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)

test: $(SIM_BIN)
	./$(SIM_BIN) 2>&1 | tee $(LOG)
	@if grep -q "CHECKS FAILED" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q "ALL CHECKS PASSED" $(LOG); then echo "simulation ended early"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
